//--- include/vcu_consts.svh
// vector control unit constants
`ifndef VCU_CONSTS_SVH
`define VCU_CONSTS_SVH

`define VCU_VLEN        4096   // bits per vector register
`define VCU_PORTS       4      // write-port groups
`define VCU_DEP_DELAY   4      // extra blocked cycles after a port frees up
`define VCU_VL_RESET    128

// class strobe bit positions
`define VCU_CLS_CFG     5
`define VCU_CLS_IVV     4
`define VCU_CLS_IVI     3
`define VCU_CLS_IVX     2
`define VCU_CLS_MVV     1
`define VCU_CLS_MVX     0

// alu op codes
`define VCU_OP_NOP      5'd0
`define VCU_OP_ADD      5'd1
`define VCU_OP_SUB      5'd2
`define VCU_OP_AND      5'd3
`define VCU_OP_OR       5'd4
`define VCU_OP_XOR      5'd5
`define VCU_OP_SLL      5'd6
`define VCU_OP_SRL      5'd7
`define VCU_OP_SRA      5'd8
`define VCU_OP_SEQ      5'd9
`define VCU_OP_SNEQ     5'd10
`define VCU_OP_MUL      5'd11
`define VCU_OP_MULHU    5'd12
`define VCU_OP_MULH     5'd13
`define VCU_OP_MACC     5'd14

`endif

//--- source/vcu_pkg.sv
// vector control unit types
`include "vcu_consts.svh"

package vcu_pkg;

   typedef logic [31:0] instr_word_t;
   typedef logic [31:0] xdata_t;       // scalar operand from the scheduler
   typedef logic [31:0] vl_t;
   typedef logic [4:0]  vreg_idx_t;
   typedef logic [5:0]  cls_t;         // one-hot class strobes
   typedef logic [4:0]  alu_op_t;
   typedef logic [`VCU_PORTS-1:0] port_mask_t;

   // same layout as the low bits of vtype in rs2
   typedef struct packed {
      logic [2:0] sew;
      logic [2:0] lmul;
   } vtype_t;

   // contents of the hold register
   typedef struct packed {
      instr_word_t word;
      xdata_t      rs1;
      xdata_t      rs2;
      cls_t        cls;
   } held_instr_t;

   // decoded alu control, 20 bits
   typedef struct packed {
      alu_op_t    alu_op;
      logic [1:0] op2_sel;       // 0 vv, 1 vx, 2 vi
      logic [4:0] imm;
      logic       mask;
      logic [1:0] wdata_width;
      vreg_idx_t  vd;
   } alu_ctrl_t;

endpackage

//--- source/vcu_config.sv
// vtype and vector length registers
`timescale 1ns/1ps
`include "vcu_consts.svh"

module vcu_config (
   input  logic                clk,
   input  logic                rstn,
   input  vcu_pkg::held_instr_t hold_i,
   input  logic                held_i,
   output vcu_pkg::vtype_t     vtype_o,
   output vcu_pkg::vl_t        vl_o
);
   import vcu_pkg::*;

   localparam int VLMAX_TOP = (`VCU_VLEN / 8) << 3;   // sew 8 bits at lmul 8

   vtype_t     vtype_q, vtype_d;
   vl_t        vl_q, vl_d;
   vl_t        vlmax, vlmax_base;
   logic [2:0] lmul_neg;
   logic       cfg_take;

   // vsetivli (bits 31:30 = 11) is not handled here
   assign cfg_take = held_i & hold_i.cls[`VCU_CLS_CFG] & ~(&hold_i.word[31:30]);

   always_comb
   begin
      vtype_d = vtype_q;
      if (!hold_i.word[31])                 // vsetvli, vtype from immediate
      begin
         vtype_d.lmul = hold_i.word[22:20];
         vtype_d.sew  = hold_i.word[25:23];
      end
      else if (!hold_i.word[30])            // vsetvl
         vtype_d = vtype_t'(hold_i.rs2[5:0]);
   end

   assign vlmax_base = vl_t'(`VCU_VLEN / 8) >> vtype_d.sew;
   assign lmul_neg   = 3'd0 - vtype_d.lmul;   // 8 - lmul for the fractional codes

   always_comb
   begin
      if (!vtype_d.lmul[2])
         vlmax = vlmax_base << vtype_d.lmul[1:0];
      else if (vtype_d.lmul == 3'd4)
         vlmax = '0;                        // reserved lmul code
      else
         vlmax = vlmax_base >> lmul_neg;
   end

   // rs1 field picks the requested avl, rd field alone asks for vlmax
   always_comb
   begin
      if (hold_i.word[19:15] != 5'd0)
         vl_d = (hold_i.rs1 < vlmax) ? hold_i.rs1 : vlmax;
      else if (hold_i.word[11:7] != 5'd0)
         vl_d = vlmax;
      else
         vl_d = vl_q;
   end

   always_ff @(posedge clk)
   begin
      if (!rstn)
      begin
         vtype_q <= '{sew: 3'd2, lmul: 3'd0};
         vl_q    <= vl_t'(`VCU_VL_RESET);
      end
      else if (cfg_take)
      begin
         vtype_q <= vtype_d;
         vl_q    <= vl_d;
      end
   end

   assign vtype_o = vtype_q;
   assign vl_o    = vl_q;

   a_vl_bound: assert property (@(posedge clk) disable iff (!rstn) vl_q <= vl_t'(VLMAX_TOP));

endmodule

//--- source/vcu_decode.sv
// arithmetic instruction decode
`timescale 1ns/1ps
`include "vcu_consts.svh"

module vcu_decode (
   input  vcu_pkg::held_instr_t hold_i,
   input  vcu_pkg::vtype_t      vtype_i,
   output vcu_pkg::alu_ctrl_t   ctrl_o,
   output vcu_pkg::vreg_idx_t   vs1_o,
   output vcu_pkg::vreg_idx_t   vs2_o,
   output logic                 uses_vs1_o
);
   import vcu_pkg::*;

   logic [5:0] funct6;
   logic       opi, opm;
   logic       vv, vx, vi;
   logic       widen;
   alu_op_t    opi_op, opm_op;

   assign funct6 = hold_i.word[31:26];

   assign opi = hold_i.cls[`VCU_CLS_IVV] | hold_i.cls[`VCU_CLS_IVI] | hold_i.cls[`VCU_CLS_IVX];
   assign opm = hold_i.cls[`VCU_CLS_MVV] | hold_i.cls[`VCU_CLS_MVX];
   assign vv  = hold_i.cls[`VCU_CLS_IVV] | hold_i.cls[`VCU_CLS_MVV];
   assign vx  = hold_i.cls[`VCU_CLS_IVX] | hold_i.cls[`VCU_CLS_MVX];
   assign vi  = hold_i.cls[`VCU_CLS_IVI];

   // widening ops in the opm space start with 11
   assign widen = opm & (funct6[5:4] == 2'b11);

   always_comb
   begin
      opi_op = `VCU_OP_NOP;
      opm_op = `VCU_OP_NOP;
      case (funct6)
         6'b000000: opi_op = `VCU_OP_ADD;
         6'b000010: opi_op = `VCU_OP_SUB;
         6'b001001: opi_op = `VCU_OP_AND;
         6'b001010: opi_op = `VCU_OP_OR;
         6'b001011: opi_op = `VCU_OP_XOR;
         6'b100101: opi_op = `VCU_OP_SLL;
         6'b101000: opi_op = `VCU_OP_SRL;
         6'b101001: opi_op = `VCU_OP_SRA;
         6'b011000: opi_op = `VCU_OP_SEQ;
         6'b011001: opi_op = `VCU_OP_SNEQ;
         default:   opi_op = `VCU_OP_NOP;
      endcase
      case (funct6)
         6'b100101: opm_op = `VCU_OP_MUL;
         6'b100100: opm_op = `VCU_OP_MULHU;
         6'b100111: opm_op = `VCU_OP_MULH;
         6'b101101: opm_op = `VCU_OP_MACC;   // vmacc
         default:   opm_op = `VCU_OP_NOP;
      endcase
   end

   always_comb
   begin
      ctrl_o.alu_op = opi ? opi_op : (opm ? opm_op : `VCU_OP_NOP);
      if (vv)
         ctrl_o.op2_sel = 2'd0;
      else if (vx)
         ctrl_o.op2_sel = 2'd1;
      else if (vi)
         ctrl_o.op2_sel = 2'd2;
      else
         ctrl_o.op2_sel = 2'd3;                // no arithmetic class held
      ctrl_o.imm         = hold_i.word[19:15];
      ctrl_o.mask        = ~hold_i.word[25];   // vm bit clear means masked
      ctrl_o.wdata_width = widen ? vtype_i.sew[1:0] + 2'd2 : vtype_i.sew[1:0] + 2'd1;
      ctrl_o.vd          = hold_i.word[11:7];
   end

   assign vs1_o      = hold_i.word[19:15];
   assign vs2_o      = hold_i.word[24:20];
   assign uses_vs1_o = vv;   // vs1 field is a register only for vv forms

endmodule

//--- source/vcu_port_alloc.sv
// write-port group allocation
`timescale 1ns/1ps

module vcu_port_alloc (
   input  logic                clk,
   input  logic                rstn,
   input  logic                issue_i,
   input  logic                hazard_i,
   input  vcu_pkg::port_mask_t port_ready_i,
   output vcu_pkg::port_mask_t start_o
);
   import vcu_pkg::*;

   port_mask_t busy_q;
   port_mask_t avail;
   port_mask_t pick;

   // a port just started still shows ready for one cycle
   assign avail = port_ready_i & ~busy_q;

   // isolate lowest set bit
   assign pick = avail & port_mask_t'(~avail + 1'b1);

   assign start_o = (issue_i && !hazard_i) ? pick : '0;

   // busy from start until the lane drops ready
   always_ff @(posedge clk)
   begin
      if (!rstn)
         busy_q <= '0;
      else
         busy_q <= (busy_q | start_o) & port_ready_i;
   end

   a_start_onehot: assert property (@(posedge clk) disable iff (!rstn)
      $onehot0(start_o));

   // only a ready port that did not start in the previous cycle
   a_start_avail: assert property (@(posedge clk) disable iff (!rstn)
      (start_o & ~(port_ready_i & ~$past(start_o))) == '0);

endmodule

//--- source/vcu_hazard.sv
// read-after-write hazard tracking
`timescale 1ns/1ps
`include "vcu_consts.svh"

module vcu_hazard (
   input  logic                clk,
   input  logic                rstn,
   input  vcu_pkg::port_mask_t start_i,
   input  vcu_pkg::port_mask_t port_ready_i,
   input  vcu_pkg::vreg_idx_t  vd_i,
   input  vcu_pkg::vreg_idx_t  vs1_i,
   input  vcu_pkg::vreg_idx_t  vs2_i,
   input  logic                uses_vs1_i,
   output logic                hazard_o
);
   import vcu_pkg::*;

   localparam int CNT_W = $clog2(`VCU_DEP_DELAY + 1);

   vreg_idx_t        dest_q [`VCU_PORTS];
   logic [CNT_W-1:0] cnt_q [`VCU_PORTS];
   port_mask_t       valid_q, inflight_q, match;

   always_ff @(posedge clk)
   begin
      for (int p = 0; p < `VCU_PORTS; p++)
      begin
         if (start_i[p])
            dest_q[p] <= vd_i;
      end
   end

   always_ff @(posedge clk)
   begin
      if (!rstn)
      begin
         valid_q    <= '0;
         inflight_q <= '0;
         for (int p = 0; p < `VCU_PORTS; p++)
            cnt_q[p] <= '0;
      end
      else
      begin
         for (int p = 0; p < `VCU_PORTS; p++)
         begin
            if (start_i[p])
            begin
               valid_q[p]    <= 1'b1;
               inflight_q[p] <= 1'b1;
               cnt_q[p]      <= CNT_W'(`VCU_DEP_DELAY);
            end
            else if (|start_i && valid_q[p] && dest_q[p] == vd_i)
            begin
               valid_q[p]    <= 1'b0;      // newer writer of vd takes over
               inflight_q[p] <= 1'b0;
            end
            else if (inflight_q[p])
            begin
               if (port_ready_i[p])
                  inflight_q[p] <= 1'b0;   // lane done, start the countdown
            end
            else if (valid_q[p])
            begin
               if (cnt_q[p] == CNT_W'(1))
                  valid_q[p] <= 1'b0;
               cnt_q[p] <= cnt_q[p] - 1'b1;
            end
         end
      end
   end

   always_comb
   begin
      for (int p = 0; p < `VCU_PORTS; p++)
         match[p] = valid_q[p] &&
                    (dest_q[p] == vs2_i || (uses_vs1_i && dest_q[p] == vs1_i));
   end

   assign hazard_o = |match;

endmodule

//--- source/v_cu_top.sv
// vector control unit issue stage
`timescale 1ns/1ps
`include "vcu_consts.svh"

module v_cu_top (
   input  logic                 clk,
   input  logic                 rstn,
   input  vcu_pkg::cls_t        instr_vld_i,
   output logic                 instr_rdy_o,
   input  vcu_pkg::instr_word_t vector_instr_i,
   input  vcu_pkg::xdata_t      scalar_rs1_i,
   input  vcu_pkg::xdata_t      scalar_rs2_i,
   input  vcu_pkg::port_mask_t  port_group_ready_i,
   output vcu_pkg::port_mask_t  start_o,
   output logic [2:0]           sew_o,
   output logic [2:0]           lmul_o,
   output vcu_pkg::vl_t         vl_o,
   output vcu_pkg::alu_op_t     alu_opmode_o,
   output logic [1:0]           op2_sel_o,
   output vcu_pkg::xdata_t      alu_x_data_o,
   output logic [4:0]           alu_imm_o,
   output logic                 vector_mask_o,
   output logic [1:0]           wdata_width_o,
   output vcu_pkg::vreg_idx_t   vd_o
);
   import vcu_pkg::*;

   held_instr_t hold_q;
   logic        held_q;
   logic        take, is_cfg, issue, hazard, uses_vs1;
   vtype_t      vtype;
   alu_ctrl_t   ctrl;
   vreg_idx_t   vs1, vs2;

   assign instr_rdy_o = ~held_q;
   assign take        = (|instr_vld_i) & instr_rdy_o;
   assign is_cfg      = hold_q.cls[`VCU_CLS_CFG];
   assign issue       = held_q & ~is_cfg;   // arithmetic waiting for a port

   always_ff @(posedge clk)
   begin
      if (take)
         hold_q <= '{word: vector_instr_i, rs1: scalar_rs1_i, rs2: scalar_rs2_i,
                     cls: instr_vld_i};
   end

   // config leaves after one cycle, arithmetic on its start
   always_ff @(posedge clk)
   begin
      if (!rstn)
         held_q <= 1'b0;
      else if (take)
         held_q <= 1'b1;
      else if (held_q && (is_cfg || |start_o))
         held_q <= 1'b0;
   end

   vcu_config u_config (
      .clk     (clk),
      .rstn    (rstn),
      .hold_i  (hold_q),
      .held_i  (held_q),
      .vtype_o (vtype),
      .vl_o    (vl_o)
   );

   vcu_decode u_decode (
      .hold_i     (hold_q),
      .vtype_i    (vtype),
      .ctrl_o     (ctrl),
      .vs1_o      (vs1),
      .vs2_o      (vs2),
      .uses_vs1_o (uses_vs1)
   );

   vcu_port_alloc u_port_alloc (
      .clk          (clk),
      .rstn         (rstn),
      .issue_i      (issue),
      .hazard_i     (hazard),
      .port_ready_i (port_group_ready_i),
      .start_o      (start_o)
   );

   vcu_hazard u_hazard (
      .clk          (clk),
      .rstn         (rstn),
      .start_i      (start_o),
      .port_ready_i (port_group_ready_i),
      .vd_i         (ctrl.vd),
      .vs1_i        (vs1),
      .vs2_i        (vs2),
      .uses_vs1_i   (uses_vs1),
      .hazard_o     (hazard)
   );

   assign sew_o         = vtype.sew;
   assign lmul_o        = vtype.lmul;
   assign alu_opmode_o  = ctrl.alu_op;
   assign op2_sel_o     = ctrl.op2_sel;
   assign alu_imm_o     = ctrl.imm;
   assign vector_mask_o = ctrl.mask;
   assign wdata_width_o = ctrl.wdata_width;
   assign vd_o          = ctrl.vd;
   assign alu_x_data_o  = hold_q.rs1;   // scalar operand for vx forms

endmodule

//--- bench/tb_v_cu.sv
// issue stage testbench
`timescale 1ns/1ps
`include "vcu_consts.svh"

module tb_v_cu;
   import vcu_pkg::*;

   logic        clk;
   logic        rstn;
   cls_t        instr_vld;
   logic        instr_rdy;
   instr_word_t instr_word;
   xdata_t      rs1_val, rs2_val;
   port_mask_t  port_ready, start;
   logic [2:0]  sew, lmul;
   vl_t         vl;
   alu_op_t     alu_op;
   logic [1:0]  op2_sel, wdata_width;
   xdata_t      x_data;
   logic [4:0]  imm;
   logic        vmask;
   vreg_idx_t   vd;

   int          errors = 0;
   int          timeouts = 0;
   int          cycle = 0;
   int          start_count = 0;
   int          last_start_cycle = 0;
   int          last_start_port = 0;
   int          rise_cycle [`VCU_PORTS];
   int          lane_cnt [`VCU_PORTS];
   port_mask_t  lane_pend = '0;
   logic        freeze = 1'b0;
   logic [31:0] rng = 32'h0e31_c3a4;
   alu_ctrl_t   exp_ctrl_q [$];
   xdata_t      exp_x_q [$];
   logic [2:0]  ref_sew = 3'd2;
   logic [2:0]  ref_lmul = 3'd0;
   vl_t         ref_vl = vl_t'(`VCU_VL_RESET);

   v_cu_top v_cu_top_i (
      .clk                (clk),
      .rstn               (rstn),
      .instr_vld_i        (instr_vld),
      .instr_rdy_o        (instr_rdy),
      .vector_instr_i     (instr_word),
      .scalar_rs1_i       (rs1_val),
      .scalar_rs2_i       (rs2_val),
      .port_group_ready_i (port_ready),
      .start_o            (start),
      .sew_o              (sew),
      .lmul_o             (lmul),
      .vl_o               (vl),
      .alu_opmode_o       (alu_op),
      .op2_sel_o          (op2_sel),
      .alu_x_data_o       (x_data),
      .alu_imm_o          (imm),
      .vector_mask_o      (vmask),
      .wdata_width_o      (wdata_width),
      .vd_o               (vd)
   );

   always #10 clk = ~clk;

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s ^ (s << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic logic [31:0] rand_below(input int n);
      rng = xorshift32(rng);
      return rng % n;
   endfunction

   // expected alu control from the decode rules
   function automatic alu_ctrl_t ref_ctrl(input instr_word_t w, input cls_t c,
                                          input logic [2:0] s);
      alu_ctrl_t  r;
      logic       opi, opm;
      logic [5:0] f6;
      f6  = w[31:26];
      opi = c[`VCU_CLS_IVV] | c[`VCU_CLS_IVI] | c[`VCU_CLS_IVX];
      opm = c[`VCU_CLS_MVV] | c[`VCU_CLS_MVX];
      r.alu_op = `VCU_OP_NOP;
      if (opi)
      begin
         case (f6)
            6'b000000: r.alu_op = `VCU_OP_ADD;
            6'b000010: r.alu_op = `VCU_OP_SUB;
            6'b001001: r.alu_op = `VCU_OP_AND;
            6'b001010: r.alu_op = `VCU_OP_OR;
            6'b001011: r.alu_op = `VCU_OP_XOR;
            6'b100101: r.alu_op = `VCU_OP_SLL;
            6'b101000: r.alu_op = `VCU_OP_SRL;
            6'b101001: r.alu_op = `VCU_OP_SRA;
            6'b011000: r.alu_op = `VCU_OP_SEQ;
            6'b011001: r.alu_op = `VCU_OP_SNEQ;
            default:   r.alu_op = `VCU_OP_NOP;
         endcase
      end
      else if (opm)
      begin
         case (f6)
            6'b100101: r.alu_op = `VCU_OP_MUL;
            6'b100100: r.alu_op = `VCU_OP_MULHU;
            6'b100111: r.alu_op = `VCU_OP_MULH;
            6'b101101: r.alu_op = `VCU_OP_MACC;
            default:   r.alu_op = `VCU_OP_NOP;
         endcase
      end
      if (c[`VCU_CLS_IVV] || c[`VCU_CLS_MVV])
         r.op2_sel = 2'd0;
      else if (c[`VCU_CLS_IVI])
         r.op2_sel = 2'd2;
      else
         r.op2_sel = 2'd1;
      r.imm  = w[19:15];
      r.mask = ~w[25];
      r.vd   = w[11:7];
      if (opm && f6[5:4] == 2'b11)
         r.wdata_width = s[1:0] + 2'd2;
      else
         r.wdata_width = s[1:0] + 2'd1;
      return r;
   endfunction

   function automatic vl_t ref_vlmax(input logic [2:0] s, input logic [2:0] l);
      vl_t m;
      m = vl_t'(`VCU_VLEN / 8) >> s;
      if (l < 3'd4)
         m = m << l;
      else if (l == 3'd4)
         m = '0;   // reserved lmul
      else
         m = m >> (4'd8 - {1'b0, l});
      return m;
   endfunction

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp)
      begin
         $display("Error at %0t: %s is %0h, expected %0h", $time, name, got, exp);
         errors++;
      end
   endtask

   // lane model drives ready, then start_o is compared once it has settled
   always @(negedge clk)
   begin
      port_mask_t st, exp_port;
      alu_ctrl_t  ec;
      xdata_t     ex;
      cycle++;
      for (int p = 0; p < `VCU_PORTS; p++)
      begin
         if (lane_pend[p])
            port_ready[p] = 1'b0;   // lane busy the cycle after start
         else if (!port_ready[p] && !freeze)
         begin
            if (lane_cnt[p] <= 1)
            begin
               port_ready[p] = 1'b1;
               rise_cycle[p] = cycle;
            end
            else
               lane_cnt[p]--;
         end
      end
      #1;
      st = start;
      if (rstn && st != '0)
      begin
         // a port started last cycle has already dropped ready
         exp_port = '0;
         for (int p = `VCU_PORTS - 1; p >= 0; p--)
            if (port_ready[p])
               exp_port = port_mask_t'(1) << p;
         check("start_o", 32'(st), 32'(exp_port));
         if (exp_ctrl_q.size() == 0)
         begin
            $display("start pulse at %0t with no instruction pending", $time);
            errors++;
         end
         else
         begin
            ec = exp_ctrl_q.pop_front();
            ex = exp_x_q.pop_front();
            check("alu_opmode_o", 32'(alu_op), 32'(ec.alu_op));
            check("op2_sel_o", 32'(op2_sel), 32'(ec.op2_sel));
            check("alu_x_data_o", x_data, ex);
            check("alu_imm_o", 32'(imm), 32'(ec.imm));
            check("vector_mask_o", 32'(vmask), 32'(ec.mask));
            check("wdata_width_o", 32'(wdata_width), 32'(ec.wdata_width));
            check("vd_o", 32'(vd), 32'(ec.vd));
         end
         start_count++;
         last_start_cycle = cycle;
         for (int p = 0; p < `VCU_PORTS; p++)
            if (st[p])
            begin
               last_start_port = p;
               lane_cnt[p]     = 3 + int'(rand_below(8));
            end
      end
      lane_pend = rstn ? st : '0;
   end

   task automatic send(input cls_t c, input instr_word_t w, input xdata_t r1, input xdata_t r2);
      int n;
      n = 0;
      while (!instr_rdy && n < 200)
      begin
         @(negedge clk);
         n++;
      end
      if (!instr_rdy)
      begin
         $display("timeout at %0t waiting for instr_rdy_o", $time);
         timeouts++;
      end
      else
      begin
         instr_vld  = c;
         instr_word = w;
         rs1_val    = r1;
         rs2_val    = r2;
         @(posedge clk);
         @(negedge clk);
         instr_vld = '0;
      end
   endtask

   task automatic send_arith(input cls_t c, input logic [5:0] f6, input logic [4:0] v2,
                             input logic [4:0] v1, input logic [4:0] d);
      instr_word_t w;
      xdata_t      r1;
      w  = {f6, rand_below(2) == 0, v2, v1, 3'(rand_below(8)), d, 7'h57};
      r1 = rand_below(32'hffff_ffff);
      exp_ctrl_q.push_back(ref_ctrl(w, c, ref_sew));
      exp_x_q.push_back(r1);
      send(c, w, r1, rand_below(1000));
   endtask

   task automatic wait_starts(input int target);
      int n;
      n = 0;
      while (start_count < target && n < 200)
      begin
         @(negedge clk);
         n++;
      end
      if (start_count < target)
      begin
         $display("timeout at %0t waiting for a start pulse", $time);
         timeouts++;
      end
   endtask

   task automatic wait_lanes_idle();
      int n;
      n = 0;
      while ((port_ready != '1 || lane_pend != '0) && n < 200)
      begin
         @(negedge clk);
         n++;
      end
      if (port_ready != '1 || lane_pend != '0)
      begin
         $display("timeout at %0t waiting for idle lanes", $time);
         timeouts++;
      end
   endtask

   initial
   begin
      logic [5:0]  opi_codes [10];
      logic [5:0]  opm_codes [4];
      cls_t        c;
      logic [5:0]  f6;
      instr_word_t w;
      xdata_t      r1, r2;
      logic [2:0]  s, l;
      int          base, pport, pstart;
      opi_codes = '{6'b000000, 6'b000010, 6'b001001, 6'b001010, 6'b001011,
                    6'b100101, 6'b101000, 6'b101001, 6'b011000, 6'b011001};
      opm_codes = '{6'b100101, 6'b100100, 6'b100111, 6'b101101};
      clk        = 1'b0;
      rstn       = 1'b0;
      instr_vld  = '0;
      instr_word = '0;
      rs1_val    = '0;
      rs2_val    = '0;
      port_ready = '1;
      repeat (4) @(negedge clk);
      rstn = 1'b1;
      @(negedge clk);

      check("start_o", 32'(start), 32'd0);
      check("instr_rdy_o", 32'(instr_rdy), 32'd1);
      check("sew_o", 32'(sew), 32'd2);
      check("lmul_o", 32'(lmul), 32'd0);
      check("vl_o", vl, 32'd128);

      for (int i = 0; i < 20; i++)
      begin
         s  = 3'(rand_below(4));
         l  = 3'(rand_below(8));
         if (l == 3'd4)
            l = 3'd0;
         r1 = rand_below(600);
         r2 = {26'd0, s, l};
         w  = {1'b0, 5'(rand_below(32)), s, l, 5'(rand_below(3)), 3'b111,
               5'(rand_below(2)), 7'h57};
         if (rand_below(2) == 0)
            w[31:25] = 7'b1000000;   // vsetvl takes vtype from rs2
         if (w[19:15] != 5'd0)
            ref_vl = (r1 < ref_vlmax(s, l)) ? r1 : ref_vlmax(s, l);
         else if (w[11:7] != 5'd0)
            ref_vl = ref_vlmax(s, l);
         ref_sew  = s;
         ref_lmul = l;
         base     = start_count;
         send(6'b100000, w, r1, r2);
         @(negedge clk);
         check("sew_o", 32'(sew), 32'(ref_sew));
         check("lmul_o", 32'(lmul), 32'(ref_lmul));
         check("vl_o", vl, ref_vl);
         check("start count after config", start_count, base);
      end

      // vd 16..31 and sources 0..15 keep these free of hazards
      for (int i = 0; i < 40; i++)
      begin
         c = cls_t'(1) << rand_below(5);
         if (c[`VCU_CLS_MVV] || c[`VCU_CLS_MVX])
            f6 = opm_codes[rand_below(4)];
         else
            f6 = opi_codes[rand_below(10)];
         if (rand_below(8) == 0)
            f6 = 6'(rand_below(64));
         send_arith(c, f6, 5'(rand_below(16)), 5'(rand_below(16)),
                    5'(16 + rand_below(16)));
      end
      wait_starts(40);

      wait_lanes_idle();
      freeze = 1'b1;
      base   = start_count;
      for (int i = 0; i < `VCU_PORTS + 1; i++)
         send_arith(6'b010000, 6'b000000, 5'(i), 5'(i), 5'(20 + i));
      repeat (6)
      begin
         @(negedge clk);
         check("instr_rdy_o", 32'(instr_rdy), 32'd0);
      end
      check("start count with all lanes busy", start_count, base + `VCU_PORTS);
      freeze = 1'b0;
      wait_starts(base + `VCU_PORTS + 1);

      wait_lanes_idle();
      base = start_count;
      send_arith(6'b010000, 6'b000000, 5'd1, 5'd2, 5'd20);
      wait_starts(base + 1);
      pport  = last_start_port;
      pstart = last_start_cycle;
      send_arith(6'b010000, 6'b000010, 5'd20, 5'd3, 5'd25);
      wait_starts(base + 2);
      if (rise_cycle[pport] <= pstart ||
          last_start_cycle - rise_cycle[pport] < `VCU_DEP_DELAY)
      begin
         $display("Error at %0t: hazard consumer not held off by producer on port %0d",
                  $time, pport);
         errors++;
      end

      wait_lanes_idle();
      base = start_count;
      send_arith(6'b010000, 6'b000000, 5'd1, 5'd2, 5'd21);
      wait_starts(base + 1);
      send_arith(6'b010000, 6'b001001, 5'd5, 5'd6, 5'd26);
      @(negedge clk);
      check("start count for independent consumer", start_count, base + 2);
      wait_lanes_idle();

      $display("errors: %0d mismatches, %0d timeouts", errors, timeouts);
      if (errors == 0 && timeouts == 0)
         $display("SIMULATION PASSED");
      else
         $display("SIMULATION FAILED");
      $finish;
   end

endmodule

//--- src.f
+incdir+include
source/vcu_pkg.sv
source/vcu_config.sv
source/vcu_decode.sv
source/vcu_port_alloc.sv
source/vcu_hazard.sv
source/v_cu_top.sv
bench/tb_v_cu.sv

//--- run_sim.sh
#!/bin/sh
# build and run the issue stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert -f src.f --top-module tb_v_cu
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/Vtb_v_cu > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "SIMULATION FAILED" sim.log; then
   exit 1
fi
exit 0
